/* source/rv_pkg.sv */
package rv_pkg;

	localparam int unsigned xlen = 32;
	localparam logic [xlen-1:0] reset_pc = '0;
	localparam logic [31:0] ebreak_inst = 32'h0010_0073;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_system = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_imm // Used by LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		st_fetch,
		st_wait_inst,
		st_execute,
		st_halt
	} seq_state_t;

endpackage

/* source/instr_sequencer.sv */
`timescale 1ns/100ps

module instr_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic                   imem_req,
	output logic [rv_pkg::xlen-1:0] imem_addr,
	input  logic                   imem_rvalid,
	input  logic [31:0]            imem_rdata,
	output logic [31:0]            inst,
	output logic                   inst_valid,
	output logic [rv_pkg::xlen-1:0] pc,
	input  logic                   is_load,
	input  logic                   is_store,
	input  logic                   is_ebreak,
	input  logic                   mem_done,
	input  logic [rv_pkg::xlen-1:0] next_pc,
	output logic                   retire,
	output logic                   finished
);
	import rv_pkg::*;

	seq_state_t state;

	assign imem_addr = pc;
	assign inst_valid = (state == st_execute);
	assign finished = (state == st_halt);
	// EBREAK halts instead of retiring so the pc stays on its address
	assign retire = inst_valid && !is_ebreak && (!(is_load || is_store) || mem_done);

	// The request pulse is registered, so the fetch state spends one cycle raising it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_fetch;
			pc <= reset_pc;
			imem_req <= 1'b0;
		end else begin
			imem_req <= 1'b0;
			case (state)
				st_fetch: begin
					if (imem_req) begin
						state <= st_wait_inst;
					end else begin
						imem_req <= 1'b1;
					end
				end
				st_wait_inst: begin
					if (imem_rvalid) begin
						state <= st_execute;
					end
				end
				st_execute: begin
					if (is_ebreak) begin
						state <= st_halt;
					end else if (retire) begin
						pc <= next_pc;
						state <= st_fetch;
						imem_req <= 1'b1; // Next fetch goes out in the first fetch cycle
					end
				end
				default: state <= st_halt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_wait_inst && imem_rvalid) begin
			inst <= imem_rdata;
		end
	end

	a_req_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		imem_req |-> state == st_fetch);

	a_rvalid_when_waiting: assert property (@(posedge clk) disable iff (!rst_n)
		imem_rvalid |-> state == st_wait_inst);

endmodule

/* source/decode_unit.sv */
`timescale 1ns/100ps

module decode_unit (
	input  logic [31:0]             inst,
	output rv_pkg::opcode_t         opcode,
	output rv_pkg::alu_op_t         alu_op,
	output logic [4:0]              rd,
	output logic [4:0]              rs1,
	output logic [4:0]              rs2,
	output logic [rv_pkg::xlen-1:0] imm,
	output logic                    rd_we,
	output logic                    is_load,
	output logic                    is_store,
	output logic                    is_ebreak
);
	import rv_pkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic writes_rd;

	assign opcode = opcode_t'(inst[6:0]);
	assign rd = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign is_ebreak = (inst == ebreak_inst);
	assign rd_we = writes_rd && (rd != 5'd0);

	always_comb begin
		alu_op = alu_add;
		imm = '0;
		writes_rd = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		case (opcode)
			op_lui: begin
				alu_op = alu_pass_imm;
				imm = imm_u;
				writes_rd = 1'b1;
			end
			op_imm: begin
				imm = imm_i;
				writes_rd = (funct3 == 3'b000); // ADDI only
			end
			op_reg: begin
				writes_rd = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'b000}: alu_op = alu_add;
					{7'h20, 3'b000}: alu_op = alu_sub;
					{7'h00, 3'b111}: alu_op = alu_and;
					{7'h00, 3'b110}: alu_op = alu_or;
					{7'h00, 3'b100}: alu_op = alu_xor;
					{7'h00, 3'b010}: alu_op = alu_slt;
					default: writes_rd = 1'b0;
				endcase
			end
			op_load: begin
				imm = imm_i;
				is_load = (funct3 == 3'b010);
				writes_rd = (funct3 == 3'b010);
			end
			op_store: begin
				imm = imm_s;
				is_store = (funct3 == 3'b010);
			end
			op_branch: begin
				imm = imm_b;
				// BEQ compares by subtraction and BNE by XOR, other branches never take
				if (funct3 == 3'b000) begin
					alu_op = alu_sub;
				end else if (funct3 == 3'b001) begin
					alu_op = alu_xor;
				end
			end
			op_jal: begin
				imm = imm_j;
				writes_rd = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* source/alu_branch_unit.sv */
`timescale 1ns/100ps

module alu_branch_unit (
	input  rv_pkg::opcode_t         opcode,
	input  rv_pkg::alu_op_t         alu_op,
	input  logic [rv_pkg::xlen-1:0] src1,
	input  logic [rv_pkg::xlen-1:0] src2,
	input  logic [rv_pkg::xlen-1:0] imm,
	input  logic [rv_pkg::xlen-1:0] pc,
	output logic [rv_pkg::xlen-1:0] alu_result,
	output logic [rv_pkg::xlen-1:0] next_pc
);
	import rv_pkg::*;

	logic [xlen-1:0] operand_b;
	logic [xlen-1:0] alu_value;
	logic [xlen-1:0] link;
	logic is_zero;
	logic taken;

	// Register forms and branches compare rs2, everything else adds the immediate
	assign operand_b = (opcode == op_reg || opcode == op_branch) ? src2 : imm;

	always_comb begin
		case (alu_op)
			alu_add: alu_value = src1 + operand_b;
			alu_sub: alu_value = src1 - operand_b;
			alu_and: alu_value = src1 & operand_b;
			alu_or: alu_value = src1 | operand_b;
			alu_xor: alu_value = src1 ^ operand_b;
			alu_slt: alu_value = {{(xlen-1){1'b0}}, $signed(src1) < $signed(operand_b)};
			alu_pass_imm: alu_value = imm;
			default: alu_value = '0;
		endcase
	end

	assign link = pc + 32'd4;
	assign is_zero = (alu_value == '0); // Both SUB and XOR give zero on equal operands

	always_comb begin
		taken = 1'b0;
		if (opcode == op_branch) begin
			if (alu_op == alu_sub) begin
				taken = is_zero;
			end else if (alu_op == alu_xor) begin
				taken = !is_zero;
			end
		end
	end

	assign alu_result = (opcode == op_jal) ? link : alu_value;
	assign next_pc = (taken || opcode == op_jal) ? pc + imm : link;

endmodule

/* source/load_store_unit.sv */
`timescale 1ns/100ps

module load_store_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    inst_valid,
	input  logic                    is_load,
	input  logic                    is_store,
	input  logic [rv_pkg::xlen-1:0] src1,
	input  logic [rv_pkg::xlen-1:0] src2,
	input  logic [rv_pkg::xlen-1:0] imm,
	output logic                    dmem_req,
	output logic                    dmem_we,
	output logic [rv_pkg::xlen-1:0] dmem_addr,
	output logic [rv_pkg::xlen-1:0] dmem_wdata,
	input  logic                    dmem_rvalid,
	input  logic [rv_pkg::xlen-1:0] dmem_rdata,
	output logic [rv_pkg::xlen-1:0] load_data,
	output logic                    mem_done
);

	logic issued; // A request is outstanding for the current instruction

	assign dmem_req = inst_valid && (is_load || is_store) && !issued;
	assign dmem_we = is_store;
	assign dmem_addr = src1 + imm;
	assign dmem_wdata = src2;
	assign mem_done = issued && dmem_rvalid;
	assign load_data = dmem_rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issued <= 1'b0;
		end else if (mem_done) begin
			issued <= 1'b0;
		end else if (dmem_req) begin
			issued <= 1'b1;
		end
	end

	a_rvalid_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_rvalid |-> issued);

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [4:0]              rs1,
	input  logic [4:0]              rs2,
	input  logic [4:0]              rd,
	input  logic [rv_pkg::xlen-1:0] wdata,
	input  logic                    wen,
	input  logic                    valid,
	output logic [rv_pkg::xlen-1:0] src1,
	output logic [rv_pkg::xlen-1:0] src2,
	output logic [rv_pkg::xlen-1:0] halt_ret
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && valid && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];
	assign halt_ret = regs[10]; // a0 carries the program result

endmodule

/* source/core_top.sv */
`timescale 1ns/100ps

module core_top (
	input  logic                    clk,
	input  logic                    rst_n,
	output logic                    imem_req,
	output logic [rv_pkg::xlen-1:0] imem_addr,
	input  logic                    imem_rvalid,
	input  logic [31:0]             imem_rdata,
	output logic                    dmem_req,
	output logic                    dmem_we,
	output logic [rv_pkg::xlen-1:0] dmem_addr,
	output logic [rv_pkg::xlen-1:0] dmem_wdata,
	input  logic                    dmem_rvalid,
	input  logic [rv_pkg::xlen-1:0] dmem_rdata,
	output logic [rv_pkg::xlen-1:0] pc,
	output logic                    finished,
	output logic [rv_pkg::xlen-1:0] halt_ret
);
	import rv_pkg::*;

	logic [31:0] inst;
	logic inst_valid;
	opcode_t opcode;
	alu_op_t alu_op;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [xlen-1:0] imm;
	logic rd_we;
	logic is_load;
	logic is_store;
	logic is_ebreak;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] next_pc;
	logic [xlen-1:0] load_data;
	logic mem_done;
	logic retire;
	logic [xlen-1:0] wb_data;

	assign wb_data = is_load ? load_data : alu_result;

	instr_sequencer instr_sequencer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_rvalid(imem_rvalid),
		.imem_rdata(imem_rdata),
		.inst(inst),
		.inst_valid(inst_valid),
		.pc(pc),
		.is_load(is_load),
		.is_store(is_store),
		.is_ebreak(is_ebreak),
		.mem_done(mem_done),
		.next_pc(next_pc),
		.retire(retire),
		.finished(finished)
	);

	decode_unit decode_unit_inst (
		.inst(inst),
		.opcode(opcode),
		.alu_op(alu_op),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.imm(imm),
		.rd_we(rd_we),
		.is_load(is_load),
		.is_store(is_store),
		.is_ebreak(is_ebreak)
	);

	alu_branch_unit alu_branch_unit_inst (
		.opcode(opcode),
		.alu_op(alu_op),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.pc(pc),
		.alu_result(alu_result),
		.next_pc(next_pc)
	);

	load_store_unit load_store_unit_inst (
		.clk(clk),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.is_load(is_load),
		.is_store(is_store),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rvalid(dmem_rvalid),
		.dmem_rdata(dmem_rdata),
		.load_data(load_data),
		.mem_done(mem_done)
	);

	reg_file reg_file_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.wdata(wb_data),
		.wen(rd_we),
		.valid(retire),
		.src1(src1),
		.src2(src2),
		.halt_ret(halt_ret)
	);

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n,
	input  logic reset_req
);

	initial clk = 1'b0;

	always #5 clk = ~clk;

	// Reset holds for 5 cycles at start and again after every reset_req pulse
	always begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge reset_req);
	end

endmodule

/* verif/core_ref_model.svh */
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

localparam logic [31:0] lfsr_taps = 32'h8020_0003;

logic [31:0] lfsr_state = 32'hf706;
logic [31:0] prog [64];
logic [xlen-1:0] exp_fetch [$];
logic [xlen-1:0] exp_store_addr [$];
logic [xlen-1:0] exp_store_data [$];
logic [xlen-1:0] exp_x10;
logic [xlen-1:0] exp_halt_pc;

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] value;
	logic out_bit;
	value = '0;
	for (int i = 0; i < n; i++) begin
		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit) begin
			lfsr_state = lfsr_state ^ lfsr_taps;
		end
		value = {value[30:0], out_bit};
	end
	return value;
endfunction

function automatic logic [31:0] data_fill(input logic [31:0] addr);
	return (addr * 32'h9e37_79b1) ^ 32'h0f0f_5a5a;
endfunction

// Kinds are 0 lui, 1 addi, 2 reg, 3 load, 4 store, 5 branch, 6 jal
function automatic logic [31:0] gen_inst(input int mode, input int idx);
	int kind_map [8];
	int kind;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [31:0] sel;
	logic [11:0] off;
	logic [9:0] f;
	logic [31:0] result;
	case (mode)
		0: kind_map = '{0, 1, 2, 2, 2, 2, 4, 4};
		1: kind_map = '{0, 1, 2, 2, 4, 4, 3, 3};
		2: kind_map = '{0, 1, 2, 2, 4, 5, 5, 6};
		default: kind_map = '{0, 1, 2, 3, 4, 5, 6, 2};
	endcase
	rd = 5'(rand_bits(4)); // x0 comes up now and then as a discarded write
	rs1 = 5'(rand_bits(4));
	rs2 = 5'(rand_bits(4));
	kind = kind_map[3'(rand_bits(3))];
	if ((kind == 5 || kind == 6) && idx >= 39) begin
		kind = 1; // A jump here would skip the EBREAK
	end
	off = (mode == 1) ? 12'(256 + 4 * rand_bits(3)) : 12'(256 + 4 * rand_bits(6));
	result = ebreak_inst;
	case (kind)
		0: begin
			sel = rand_bits(20);
			result = {sel[19:0], rd, op_lui};
		end
		1: begin
			sel = rand_bits(12);
			result = {sel[11:0], rs1, 3'b000, rd, op_imm};
		end
		2: begin
			sel = rand_bits(3) % 6;
			case (sel)
				0: f = {7'h00, 3'b000};
				1: f = {7'h20, 3'b000};
				2: f = {7'h00, 3'b111};
				3: f = {7'h00, 3'b110};
				4: f = {7'h00, 3'b100};
				default: f = {7'h00, 3'b010};
			endcase
			result = {f[9:3], rs2, rs1, f[2:0], rd, op_reg};
		end
		3: result = {off, 5'd0, 3'b010, rd, op_load};
		4: result = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], op_store};
		5: begin
			if (rand_bits(1) != 0) begin
				rs2 = rs1; // Equal operands make BEQ taken
			end
			sel = rand_bits(1);
			result = {7'b0, rs2, rs1, 2'b00, sel[0], 4'b0100, 1'b0, op_branch};
		end
		default: result = {1'b0, 10'b0000000100, 1'b0, 8'b0, rd, op_jal};
	endcase
	return result;
endfunction

task automatic load_program(input int mode);
	for (int i = 0; i < 40; i++) begin
		prog[i] = gen_inst(mode, i);
	end
	for (int i = 40; i < 64; i++) begin
		prog[i] = ebreak_inst;
	end
endtask

function automatic void run_reference();
	logic [xlen-1:0] regs [32];
	logic [xlen-1:0] mem [128];
	logic [xlen-1:0] pc_r;
	logic [xlen-1:0] next_r;
	logic [xlen-1:0] addr;
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] value;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_j;
	logic [31:0] ins;
	logic write;
	exp_fetch.delete();
	exp_store_addr.delete();
	exp_store_data.delete();
	for (int i = 0; i < 32; i++) begin
		regs[i] = '0;
	end
	for (int i = 0; i < 128; i++) begin
		mem[i] = data_fill(32'(i * 4));
	end
	pc_r = reset_pc;
	exp_halt_pc = '0;
	for (int step = 0; step < 200; step++) begin
		ins = prog[pc_r[7:2]];
		exp_fetch.push_back(pc_r);
		if (ins == ebreak_inst) begin
			exp_halt_pc = pc_r;
			break;
		end
		a = regs[ins[19:15]];
		b = regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		write = 1'b1;
		value = '0;
		next_r = pc_r + 4;
		case (ins[6:0])
			op_lui: value = {ins[31:12], 12'b0};
			op_imm: value = a + imm_i;
			op_reg: begin
				case ({ins[30], ins[14:12]})
					4'b1000: value = a - b;
					4'b0111: value = a & b;
					4'b0110: value = a | b;
					4'b0100: value = a ^ b;
					4'b0010: value = {31'b0, $signed(a) < $signed(b)};
					default: value = a + b;
				endcase
			end
			op_load: begin
				addr = a + imm_i;
				value = mem[addr[8:2]];
			end
			op_store: begin
				addr = a + imm_s;
				mem[addr[8:2]] = b;
				exp_store_addr.push_back(addr);
				exp_store_data.push_back(b);
				write = 1'b0;
			end
			op_branch: begin
				write = 1'b0;
				if ((a == b) != ins[12]) begin
					next_r = pc_r + imm_b;
				end
			end
			default: begin
				value = pc_r + 4; // JAL link
				next_r = pc_r + imm_j;
			end
		endcase
		if (write && ins[11:7] != 5'd0) begin
			regs[ins[11:7]] = value;
		end
		pc_r = next_r;
	end
	exp_x10 = regs[10];
endfunction

`endif

/* verif/core_tb.sv */
`timescale 1ns/100ps

module core_tb;
	import rv_pkg::*;

	`include "core_ref_model.svh"

	logic clk;
	logic rst_n;
	logic reset_req;
	logic imem_req;
	logic [xlen-1:0] imem_addr;
	logic imem_rvalid;
	logic [31:0] imem_rdata;
	logic dmem_req;
	logic dmem_we;
	logic [xlen-1:0] dmem_addr;
	logic [xlen-1:0] dmem_wdata;
	logic dmem_rvalid;
	logic [xlen-1:0] dmem_rdata;
	logic [xlen-1:0] pc;
	logic finished;
	logic [xlen-1:0] halt_ret;

	logic [31:0] imem_model [64];
	logic [xlen-1:0] dmem_model [128];
	int imem_delay;
	int dmem_delay;
	logic [31:0] imem_pending;
	logic [xlen-1:0] dmem_pending;

	tb_clock_gen clock_gen_inst (
		.clk(clk),
		.rst_n(rst_n),
		.reset_req(reset_req)
	);

	core_top core_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_rvalid(imem_rvalid),
		.imem_rdata(imem_rdata),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rvalid(dmem_rvalid),
		.dmem_rdata(dmem_rdata),
		.pc(pc),
		.finished(finished),
		.halt_ret(halt_ret)
	);

	// Instruction memory answers 1 to 4 cycles after the request
	always @(posedge clk) begin
		#1;
		imem_rvalid = 1'b0;
		if (!rst_n) begin
			imem_delay = 0;
		end else if (imem_delay > 0) begin
			imem_delay--;
			if (imem_delay == 0) begin
				imem_rvalid = 1'b1;
				imem_rdata = imem_pending;
			end
		end else if (imem_req) begin
			imem_pending = imem_model[imem_addr[7:2]];
			imem_delay = 1 + int'(rand_bits(2));
		end
	end

	always @(posedge clk) begin
		#1;
		dmem_rvalid = 1'b0;
		if (!rst_n) begin
			dmem_delay = 0;
		end else if (dmem_delay > 0) begin
			dmem_delay--;
			if (dmem_delay == 0) begin
				dmem_rvalid = 1'b1;
				dmem_rdata = dmem_pending;
			end
		end else if (dmem_req) begin
			dmem_pending = dmem_model[dmem_addr[8:2]];
			if (dmem_we) begin
				dmem_model[dmem_addr[8:2]] = dmem_wdata;
			end
			dmem_delay = 1 + int'(rand_bits(2));
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_pc(input string name, input logic [xlen-1:0] actual,
			input logic [xlen-1:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
			input logic [xlen-1:0] exp_addr, input logic [xlen-1:0] exp_data);
		if (addr !== exp_addr) begin
			fail_run($sformatf("mismatch at %0t: dmem_addr is %h, expected %h",
				$time, addr, exp_addr));
		end
		if (data !== exp_data) begin
			fail_run($sformatf("mismatch at %0t: dmem_wdata is %h, expected %h",
				$time, data, exp_data));
		end
	endtask

	task automatic check_halt_ret(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch at %0t: halt_ret is %h, expected %h",
				$time, actual, expected));
		end
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			// The cycle right after the release is covered too
			if (imem_req !== 1'b0 || dmem_req !== 1'b0 || finished !== 1'b0) begin
				fail_run("a request or finished was active during or right after reset");
			end
			cycles++;
			if (cycles > 20) begin
				fail_run("timeout: reset was never released");
			end
		end
	endtask

	task automatic run_program(input int mode, input bit is_first);
		int fetch_idx;
		int store_idx;
		bit done;
		load_program(mode);
		for (int i = 0; i < 64; i++) begin
			imem_model[i] = prog[i];
		end
		for (int i = 0; i < 128; i++) begin
			dmem_model[i] = data_fill(32'(i * 4));
		end
		run_reference();
		if (!is_first) begin
			@(posedge clk);
			#1;
			reset_req = 1'b1;
			@(negedge clk);
			reset_req = 1'b0;
		end
		wait_reset_release();
		fetch_idx = 0;
		store_idx = 0;
		done = 1'b0;
		for (int cycles = 0; cycles < 5000 && !done; cycles++) begin
			@(negedge clk);
			if (imem_req) begin
				if (fetch_idx == 0) begin
					check_pc("imem_addr", imem_addr, reset_pc);
				end
				if (fetch_idx >= exp_fetch.size()) begin
					fail_run("the core fetched more instructions than the reference");
				end
				check_pc("imem_addr", imem_addr, exp_fetch[fetch_idx]);
				fetch_idx++;
			end
			if (dmem_req && dmem_we) begin
				if (store_idx >= exp_store_addr.size()) begin
					fail_run("the core issued more stores than the reference");
				end
				check_store(dmem_addr, dmem_wdata, exp_store_addr[store_idx],
					exp_store_data[store_idx]);
				store_idx++;
			end
			done = finished;
		end
		if (!done) begin
			fail_run("timeout: finished never rose after EBREAK");
		end
		check_halt_ret(halt_ret, exp_x10);
		check_pc("pc", pc, exp_halt_pc);
		if (fetch_idx != exp_fetch.size() || store_idx != exp_store_addr.size()) begin
			fail_run("the core halted with fewer fetches or stores than the reference");
		end
		repeat (20) begin
			@(negedge clk);
			if (imem_req || dmem_req || !finished) begin
				fail_run("the core left the halt state or made a request");
			end
		end
	endtask

	initial begin
		reset_req = 1'b0;
		imem_rvalid = 1'b0;
		imem_rdata = '0;
		dmem_rvalid = 1'b0;
		dmem_rdata = '0;
		imem_delay = 0;
		dmem_delay = 0;
		run_program(0, 1'b1); // ALU, LUI and stores
		run_program(1, 1'b0);
		run_program(2, 1'b0);
		repeat (5) run_program(3, 1'b0);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* project.f */
+incdir+verif
source/rv_pkg.sv
source/instr_sequencer.sv
source/decode_unit.sv
source/alu_branch_unit.sv
source/load_store_unit.sv
source/reg_file.sv
source/core_top.sv
verif/tb_clock_gen.sv
verif/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

if ! verilator --binary --timing --assert -f project.f --top-module core_tb -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vcore_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi

if [ "$run_status" -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation passed"
exit 0
